// ==== verif/enc_vectors.txt ====
# test op args; F/B = channel steps gap, G = channel width, D = cycles, all decimal
# W = waddr wdata, R = addr expected, both hex; E ends the test
1 R 19 00000000
1 R 1a 00000001
1 R 1b 00000002
1 R 1c 00000003
1 R 01 00800000
1 R 02 00800000
1 R 03 00800000
1 R 04 00800000
1 R 09 00000000
1 R 0a 00000000
1 R 0b 00000000
1 R 0c 00000000
1 R 11 00000000
1 R 00 00000b1d
1 R 05 00000b1d
1 R 21 00800000
1 E
2 F 2 10 8
2 R 02 0080000a
2 R 0a 80000008
2 B 2 3 8
2 R 1a 00000001
2 R 0a 00000008
2 R 02 00800007
2 R 01 00800000
2 R 03 00800000
2 R 04 00800000
2 E
3 W 0034 ab123456
3 D 1
3 R 03 00123456
3 W 1034 00555555
3 W 0035 00555555
3 W 0004 00555555
3 W 0054 00555555
3 D 2
3 R 01 00800000
3 R 02 00800007
3 R 03 00123456
3 R 04 00800000
3 E
4 W 0014 00fffffe
4 D 1
4 R 01 00fffffe
4 F 1 3 8
4 R 01 01000001
4 W 0044 00000001
4 D 1
4 R 04 00000001
4 B 4 2 8
4 R 04 01ffffff
4 W 0014 00000010
4 D 1
4 R 01 00000010
4 W 0044 00abcdef
4 D 1
4 R 04 00abcdef
4 E
5 F 3 4 40
5 R 1b 00000021
5 R 0b 80000028
5 R 1b 00000023
5 R 03 0012345a
5 B 3 3 40
5 R 0b 00000028
5 R 1b 00000022
5 D 20
5 R 1b 00000037
5 R 03 00123457
5 E
6 G 2 3
6 D 10
6 R 02 00800007
6 R 0a 00000008
6 G 1 3
6 D 10
6 R 01 00000010
6 F 2 1 8
6 R 02 00800008
6 E

// ==== sim.f ====
hw/enc_pkg.sv
hw/debounce.sv
hw/enc_quad.sv
hw/enc_period.sv
hw/enc_ctrl.sv
verif/tb_enc_ctrl.sv

// ==== Makefile ====
TOP := tb_enc_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

# pass only if the testbench printed its pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verif/tb_enc_ctrl.sv ====
`default_nettype none

module tb_enc_ctrl import enc_pkg::*; ();

    // --------------------
    // DUT signals
    // --------------------
    logic                  sysclk;
    logic                  reset;
    logic [num_channels:1] enc_a;      // raw pins, bit n is channel n
    logic [num_channels:1] enc_b;
    logic [5:0]            addr;
    logic [31:0]           data;
    logic [15:0]           reg_waddr;
    logic [31:0]           reg_wdata;
    logic                  reg_wen;

    // parsed vector file, one entry per operation
    int          tnum_q [$];
    logic [7:0]  op_q   [$];
    logic [31:0] arg1_q [$];
    logic [31:0] arg2_q [$];
    logic [31:0] arg3_q [$];

    logic [1:0] phase [1:num_channels];  // quadrature state, forward counts up
    int vector_cycles = 0;               // step and wait cycles in the file
    int cycle_limit   = 100000;          // replaced once the file is read
    int cycle_cnt     = 0;
    int test_errs     = 0;               // failed checks in the running test
    int pass_cnt      = 0;
    int fail_cnt      = 0;
    int bad_lines     = 0;

    enc_ctrl u_enc_ctrl (
        .sysclk    (sysclk),
        .reset     (reset),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .addr      (addr),
        .data      (data),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // watchdog, limit comes from the vector file
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: vectors still running after %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // driver tasks
    // --------------------
    task automatic next_cycle();
        @(posedge sysclk);
        #1;                      // inputs change just after the edge
    endtask

    // one pin change per step, gray order 00 10 11 01 on {a, b}
    task automatic move_channel(input int ch, input bit fwd, input int steps, input int gap);
        for (int s = 0; s < steps; s++) begin
            if (fwd)
                phase[ch] = phase[ch] + 2'd1;
            else
                phase[ch] = phase[ch] - 2'd1;
            enc_a[ch] = phase[ch][0] ^ phase[ch][1];
            enc_b[ch] = phase[ch][1];
            repeat (gap) next_cycle();
        end
    endtask

    // short pulse on A, then back to the old level
    task automatic pulse_line_a(input int ch, input int width);
        enc_a[ch] = ~enc_a[ch];
        repeat (width) next_cycle();
        enc_a[ch] = ~enc_a[ch];
    endtask

    task automatic apply_write(input logic [15:0] wa, input logic [31:0] wd);
        reg_waddr = wa;
        reg_wdata = wd;
        reg_wen   = 1'b1;
        next_cycle();            // the write edge
        reg_wen   = 1'b0;
    endtask

    // read port is combinational, sample mid cycle
    task automatic check_read(input logic [5:0] ra, input logic [31:0] exp);
        addr = ra;
        #3;
        assert (data === exp) else begin
            $display("Mismatch data: addr 0x%h expected 0x%h actual 0x%h", ra, exp, data);
            test_errs++;
        end
        next_cycle();
    endtask

    task automatic finish_test(input int tnum);
        if (test_errs == 0) begin
            $display("test %0d passed", tnum);
            pass_cnt++;
        end else begin
            $display("test %0d failed with %0d bad reads", tnum, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    // --------------------
    // vector file
    // --------------------
    task automatic load_vectors();
        int          fd;
        int          n;
        int          want;
        int          line_no;
        int          tnum;
        bit          chan_ok;
        logic [7:0]  op;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        string       line;

        line_no = 0;
        fd = $fopen("verif/enc_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/enc_vectors.txt");
            bad_lines++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() > 1 && line[0] != "#") begin   // skip blanks and notes
                    a1 = '0;
                    a2 = '0;
                    a3 = '0;
                    op = 8'h00;
                    n = $sscanf(line, "%d %c", tnum, op);
                    case (op)
                        "F", "B": begin                  // channel steps gap
                            want = 5;
                            n = $sscanf(line, "%d %c %d %d %d", tnum, op, a1, a2, a3);
                            vector_cycles += a2 * a3;
                        end
                        "G": begin                       // channel width
                            want = 4;
                            n = $sscanf(line, "%d %c %d %d", tnum, op, a1, a2);
                            vector_cycles += a2;
                        end
                        "W", "R": begin                  // address value, hex
                            want = 4;
                            n = $sscanf(line, "%d %c %h %h", tnum, op, a1, a2);
                        end
                        "D": begin
                            want = 3;
                            n = $sscanf(line, "%d %c %d", tnum, op, a1);
                            vector_cycles += a1;
                        end
                        "E": want = 2;
                        default: want = 0;
                    endcase
                    chan_ok = !(op == "F" || op == "B" || op == "G")
                              || (a1 >= 1 && a1 <= num_channels);
                    assert (want != 0 && n == want) else begin
                        $display("vector line %0d is malformed or has an unknown operation",
                                 line_no);
                        bad_lines++;
                    end
                    assert (chan_ok) else begin
                        $display("vector line %0d names channel %0d, which does not exist",
                                 line_no, a1);
                        bad_lines++;
                    end
                    if (want != 0 && n == want && chan_ok) begin
                        tnum_q.push_back(tnum);
                        op_q.push_back(op);
                        arg1_q.push_back(a1);
                        arg2_q.push_back(a2);
                        arg3_q.push_back(a3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vectors();
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "F": move_channel(arg1_q[i], 1'b1, arg2_q[i], arg3_q[i]);
                "B": move_channel(arg1_q[i], 1'b0, arg2_q[i], arg3_q[i]);
                "G": pulse_line_a(arg1_q[i], arg2_q[i]);
                "W": apply_write(arg1_q[i][15:0], arg2_q[i]);
                "D": repeat (arg1_q[i]) next_cycle();
                "R": check_read(arg1_q[i][5:0], arg2_q[i]);
                default: finish_test(tnum_q[i]);   // end of test
            endcase
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        reset     = 1'b0;
        enc_a     = '0;
        enc_b     = '0;
        addr      = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        for (int ch = 1; ch <= num_channels; ch++)
            phase[ch] = 2'd0;                      // pins start at 00

        load_vectors();
        cycle_limit = 2 * vector_cycles + 1000;

        repeat (16) @(posedge sysclk);
        #1;
        reset = 1'b1;

        run_vectors();
        if (test_errs != 0) begin                  // checks with no end line
            $display("%0d bad reads after the last end of test", test_errs);
            fail_cnt++;
        end

        $display("tests passed: %0d, tests failed: %0d, bad vector lines: %0d",
                 pass_cnt, fail_cnt, bad_lines);
        if (fail_cnt == 0 && bad_lines == 0 && pass_cnt > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/enc_ctrl.sv ====
`default_nettype none

// encoder block top
// filters, decoders and speed counters per channel, preload writes, read mux
module enc_ctrl import enc_pkg::*; (
    input  wire                   sysclk,
    input  wire                   reset,      // sync, active low
    input  wire  [num_channels:1] enc_a,      // raw A pins, bit n is channel n
    input  wire  [num_channels:1] enc_b,      // raw B pins
    input  wire  [5:0]            addr,       // read address, bit 5 unused
    output logic [31:0]           data,       // read word, combinational
    input  wire  [15:0]           reg_waddr,  // write address
    input  wire  [31:0]           reg_wdata,  // write data, low 24 bits used
    input  wire                   reg_wen     // write strobe
);

    // --------------------
    // per-channel wires
    // --------------------
    logic [num_channels:1] enc_a_filt;                // filtered A
    logic [num_channels:1] enc_b_filt;                // filtered B
    logic [num_channels:1] dir;                       // step direction
    logic [num_channels:1] set_enc;                   // preload strobe
    logic [23:0]           preload   [1:num_channels]; // preload registers
    logic [24:0]           quad_data [1:num_channels]; // {ovf, count}
    logic [31:0]           perd_data [1:num_channels]; // {dir, period}
    logic [31:0]           run_data  [1:num_channels]; // cycles since edge

    // write decode
    logic       wr_hit;     // block id and offset match
    logic [3:0] wr_chan;    // target channel

    // read decode
    logic [2:0] rd_chan;
    enc_off_e   rd_off;

    // --------------------
    // channel datapaths
    // --------------------
    for (genvar i = 1; i <= num_channels; i++) begin : g_chan
        debounce u_filt_a (
            .sysclk (sysclk),
            .reset  (reset),
            .raw    (enc_a[i]),
            .filt   (enc_a_filt[i])
        );

        debounce u_filt_b (
            .sysclk (sysclk),
            .reset  (reset),
            .raw    (enc_b[i]),
            .filt   (enc_b_filt[i])
        );

        // position
        enc_quad u_quad (
            .sysclk    (sysclk),
            .reset     (reset),
            .a         (enc_a_filt[i]),
            .b         (enc_b_filt[i]),
            .set       (set_enc[i]),
            .preload   (preload[i]),
            .quad_data (quad_data[i]),
            .dir       (dir[i])
        );

        // speed
        enc_period u_period (
            .sysclk    (sysclk),
            .reset     (reset),
            .a         (enc_a_filt[i]),
            .b         (enc_b_filt[i]),
            .dir       (dir[i]),
            .perd_data (perd_data[i]),
            .run_data  (run_data[i])
        );
    end

    // --------------------
    // preload writes
    // --------------------
    assign wr_hit  = reg_wen && (reg_waddr[15:12] == addr_main)
                             && (reg_waddr[3:0] == off_enc_load);
    assign wr_chan = reg_waddr[7:4];

    // preload lands one cycle after the write, set_enc pulses the next
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            set_enc <= '0;
            for (int i = 1; i <= num_channels; i++)
                preload[i] <= preload_init;     // matches the counters' reset
        end else begin
            set_enc <= '0;                      // one-cycle strobe
            for (int i = 1; i <= num_channels; i++) begin
                if (wr_hit && wr_chan == i) begin   // channel 0 never matches
                    preload[i] <= reg_wdata[23:0];
                    set_enc[i] <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // read mux
    // --------------------
    assign rd_chan = addr[2:0];
    assign rd_off  = enc_off_e'(addr[4:3]);

    always_comb begin
        data = bad_chan_word;                   // channel 0 or out of range
        for (int i = 1; i <= num_channels; i++) begin
            if (rd_chan == i) begin
                case (rd_off)
                    off_enc_data: data = {7'd0, quad_data[i]};
                    off_per_data: data = perd_data[i];
                    off_run_data: data = run_data[i];
                    default:      data = 32'd0;  // reserved slot
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/enc_period.sv ====
`default_nettype none

// speed measurement for one channel
// period between the last two edges, plus time since the latest one
module enc_period import enc_pkg::*; (
    input  wire         sysclk,
    input  wire         reset,      // sync, active low
    input  wire         a,          // filtered A
    input  wire         b,          // filtered B
    input  wire         dir,        // from the decoder
    output logic [31:0] perd_data,  // {dir, period}
    output logic [31:0] run_data    // cycles since last edge
);

    logic        a_prev;     // last cycle's pair
    logic        b_prev;
    logic        edge_seen;  // any change on A or B
    logic [31:0] run_cnt;    // free-running, restarts on each edge
    logic [30:0] perd_cnt;   // period to capture on this edge

    // --------------------
    // edge detect
    // --------------------
    // own copy of the previous pair, only dir comes from the decoder
    assign edge_seen = (a != a_prev) || (b != b_prev);

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            a_prev <= 1'b0;
            b_prev <= 1'b0;
        end else begin
            a_prev <= a;
            b_prev <= b;
        end
    end

    // --------------------
    // running counter
    // --------------------
    // the edge cycle itself counts, hence the plus one
    assign perd_cnt = (run_cnt == count_max) ? count_max[30:0] : run_cnt[30:0] + 31'd1;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            run_cnt <= '0;
        end else if (edge_seen) begin
            run_cnt <= '0;                    // new interval
        end else if (run_cnt != count_max) begin
            run_cnt <= run_cnt + 32'd1;       // stalls at count_max
        end
    end

    // --------------------
    // period capture
    // --------------------
    // dir still holds the step that opened the interval
    always_ff @(posedge sysclk) begin
        if (!reset)
            perd_data <= '0;                  // zero until the first edge
        else if (edge_seen)
            perd_data <= {dir, perd_cnt};
    end

    assign run_data = run_cnt;

endmodule

`default_nettype wire

// ==== hw/enc_quad.sv ====
`default_nettype none

// x4 quadrature decoder, position counter with sticky overflow
module enc_quad import enc_pkg::*; (
    input  wire         sysclk,
    input  wire         reset,      // sync, active low
    input  wire         a,          // filtered A
    input  wire         b,          // filtered B
    input  wire         set,        // one-cycle preload strobe
    input  wire  [23:0] preload,    // value loaded on set
    output logic [24:0] quad_data,  // {ovf, count}
    output logic        dir         // 1 = forward, A leads B
);

    logic        a_prev;   // last cycle's pair
    logic        b_prev;
    logic [23:0] count;    // position
    logic        ovf;      // sticky wrap flag
    logic        step;     // legal single-line change
    logic        fwd;      // direction of this step

    // --------------------
    // step decode
    // --------------------
    // exactly one line moved; both moving at once is dropped
    assign step = (a ^ a_prev) ^ (b ^ b_prev);

    // forward order is 00 -> 10 -> 11 -> 01 -> 00 on {a, b}
    assign fwd = a ^ b_prev;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            a_prev <= 1'b0;   // filters come out of reset low
            b_prev <= 1'b0;
            dir    <= 1'b0;
        end else begin
            a_prev <= a;
            b_prev <= b;
            if (step)
                dir <= fwd;
        end
    end

    // --------------------
    // position counter
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count <= preload_init;
            ovf   <= 1'b0;
        end else if (set) begin
            count <= preload;     // load beats a same-cycle step
            ovf   <= 1'b0;
        end else if (step) begin
            if (fwd) begin
                count <= count + 24'd1;
                if (count == 24'hffffff)
                    ovf <= 1'b1;  // wrapped going up
            end else begin
                count <= count - 24'd1;
                if (count == 24'd0)
                    ovf <= 1'b1;  // wrapped going down
            end
        end
    end

    assign quad_data = {ovf, count};

endmodule

`default_nettype wire

// ==== hw/debounce.sv ====
`default_nettype none

// one encoder line, pin to clean level
module debounce import enc_pkg::*; (
    input  wire  sysclk,
    input  wire  reset,   // sync, active low
    input  wire  raw,     // async pin
    output logic filt     // filtered level
);

    logic sync_1;                      // first sync stage
    logic sync_2;                      // second sync stage, safe to use
    logic [$clog2(deb_len)-1:0] cnt;   // cycles sync_2 has differed from filt

    // --------------------
    // synchronizer
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
        end else begin
            sync_1 <= raw;
            sync_2 <= sync_1;
        end
    end

    // --------------------
    // stability counter
    // --------------------
    // filt follows only after deb_len matching samples
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            cnt  <= '0;
            filt <= 1'b0;
        end else if (sync_2 != filt) begin
            if (cnt == deb_len - 1) begin
                filt <= sync_2;       // held long enough
                cnt  <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else begin
            cnt <= '0;                // back to old level, start over
        end
    end

endmodule

`default_nettype wire

// ==== hw/enc_pkg.sv ====
`default_nettype none

package enc_pkg;

    // --------------------
    // channel setup
    // --------------------
    localparam int num_channels = 4;     // encoder channels, numbered 1 to num_channels

    // input filter
    localparam int deb_len   = 4;           // cycles a new level must hold
    localparam int deb_delay = 2 + deb_len; // two sync flops plus the filter

    // --------------------
    // register map
    // --------------------
    localparam logic [3:0] addr_main    = 4'h0; // block id in reg_waddr[15:12]
    localparam logic [3:0] off_enc_load = 4'h4; // preload offset in reg_waddr[3:0]

    // reset and fill values
    localparam logic [23:0] preload_init  = 24'h800000;   // half scale
    localparam logic [31:0] bad_chan_word = 32'd2845;     // no such channel
    localparam logic [31:0] count_max     = 32'h7fffffff; // period counter ceiling

    // read offset, addr[4:3]
    typedef enum logic [1:0] {
        off_enc_data = 2'd0,  // position plus overflow
        off_per_data = 2'd1,  // last edge-to-edge period
        off_res      = 2'd2,  // reserved, reads zero
        off_run_data = 2'd3   // cycles since latest edge
    } enc_off_e;

endpackage

`default_nettype wire
